//--- Bender.yml
package:
  name: csr_subsys

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/csr_pkg.sv
      - verilog/csr_op_unit.sv
      - verilog/machine_timer.sv
      - verilog/csr_regfile.sv
      - verilog/csr_subsys.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - bench/tb_csr_subsys.sv

//--- bench/tb_csr_subsys.sv
`timescale 1ns/100ps
`include "csr_macros.svh"

module tb_csr_subsys;
  import csr_pkg::*;

  localparam logic [2:0] k_csr   = 3'd0;
  localparam logic [2:0] k_trap  = 3'd1;
  localparam logic [2:0] k_poll  = 3'd2;
  localparam logic [2:0] k_snap  = 3'd3;
  localparam logic [2:0] k_grow  = 3'd4;
  localparam logic [2:0] k_delta = 3'd5;

  typedef struct packed {
    logic [2:0]  kind;
    csr_op_e     op;
    logic [11:0] addr;
    logic [31:0] operand;
    logic [31:0] mask;
    logic [31:0] exp;
    trap_in_t    trap;
    irq_bits_t   lines;
    logic        exp_trap;
    logic        exp_mret;
    logic [31:0] exp_target;
    logic [31:0] exp_mepc;
  } step_t;

  logic      clk;
  logic      rst;
  logic      req_valid;
  csr_req_t  req;
  logic      req_ready;
  logic      rsp_valid;
  csr_rsp_t  rsp;
  logic      rsp_ready;
  trap_in_t  trap_in;
  trap_out_t trap_out;
  logic      meip;
  logic      msip;

  step_t       steps[$];
  irq_bits_t   row_lines;  // Lines applied to rows added next.
  logic [31:0] lcg_state;
  logic [31:0] snap;
  int          cycles;
  int          limit;

  csr_subsys DUT (
    .clk, .rst, .req_valid, .req, .req_ready, .rsp_valid, .rsp, .rsp_ready,
    .trap_in, .trap_out, .meip, .msip
  );

  always #5 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= limit) begin
      stop_run($sformatf("timeout: the run did not finish within %0d cycles", limit));
    end
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  task automatic stop_run(input string msg);
    $display("%s", msg);
    $display(">>> FAIL");
    $fatal(1, "run stopped");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      stop_run($sformatf("error at %0t: %s = 0x%08h, expected 0x%08h", $time, name, got, exp));
    end
  endtask

  // Table builders ----------------------------
  task automatic csr_row(input csr_op_e op, input logic [11:0] addr,
                         input logic [31:0] operand, input logic [31:0] exp);
    step_t s;
    s = '0;
    s.kind = k_csr;
    s.op = op;
    s.addr = addr;
    s.operand = operand;
    s.exp = exp;
    s.lines = row_lines;
    steps.push_back(s);
  endtask

  task automatic count_row(input logic [2:0] kind, input logic [11:0] addr,
                           input logic [31:0] mask, input logic [31:0] exp);
    step_t s;
    s = '0;
    s.kind = kind;
    s.op = csr_op_set;  // Set with zero is a plain read.
    s.addr = addr;
    s.mask = mask;
    s.exp = exp;
    s.lines = row_lines;
    steps.push_back(s);
  endtask

  task automatic trap_row(input logic retire, input logic exc, input logic [3:0] ecause,
                          input logic [31:0] epc, input logic [31:0] etval,
                          input logic mret, input logic exp_trap, input logic exp_mret,
                          input logic [31:0] target, input logic [31:0] mepc);
    step_t s;
    s = '0;
    s.kind = k_trap;
    s.trap = '{retire_valid: retire, exception: exc, ecause: ecause, epc: epc,
               etval: etval, mret: mret};
    s.lines = row_lines;
    s.exp_trap = exp_trap;
    s.exp_mret = exp_mret;
    s.exp_target = target;
    s.exp_mepc = mepc;
    steps.push_back(s);
  endtask

  // Bus drivers -------------------------------
  task automatic do_csr_op(input step_t s, output logic [31:0] got);
    int stall;
    stall = int'((lcg_next() >> 16) % 4);
    @(posedge clk);
    req_valid <= 1'b1;
    req <= '{op: s.op, addr: s.addr, operand: s.operand};
    @(negedge clk);
    while (!req_ready) @(negedge clk);
    @(posedge clk);
    req_valid <= 1'b0;
    rsp_ready <= (stall == 0);
    @(negedge clk);
    check_value("rsp_valid", rsp_valid, 1);
    for (int i = 0; i < stall; i++) begin
      check_value("req_ready", req_ready, 0);  // Held response blocks new requests.
      @(posedge clk);
      if (i == stall - 1) rsp_ready <= 1'b1;
      @(negedge clk);
      check_value("rsp_valid", rsp_valid, 1);
    end
    got = rsp.rdata;
    @(posedge clk);
  endtask

  task automatic apply_trap(input step_t s);
    @(posedge clk);
    trap_in <= s.trap;
    @(posedge clk);
    trap_in <= '0;
    @(negedge clk);
    check_value("trap_out.trap_taken", trap_out.trap_taken, s.exp_trap);
    check_value("trap_out.mret_taken", trap_out.mret_taken, s.exp_mret);
    if (s.exp_trap) begin
      check_value("trap_out.mepc", trap_out.mepc, s.exp_mepc);
      check_value("trap_out.target", trap_out.target, s.exp_target);
    end
    @(negedge clk);
    check_value("trap_out.trap_taken", trap_out.trap_taken, 0);  // One cycle only.
    check_value("trap_out.mret_taken", trap_out.mret_taken, 0);
  endtask

  initial begin
    step_t       s;
    logic [31:0] got;
    int          tries;
    clk = 1'b0;
    rst = 1'b0;
    req_valid = 1'b0;
    req = '0;
    rsp_ready = 1'b1;
    trap_in = '0;
    meip = 1'b0;
    msip = 1'b0;
    lcg_state = 32'h797c_5dfb;
    cycles = 0;
    row_lines = '0;

    csr_row(csr_op_set, `CSR_MISA, 32'h0, `CSR_MISA_RESET);
    csr_row(csr_op_set, `CSR_MSCRATCH, 32'h0, 32'h0);
    csr_row(csr_op_set, `CSR_MSTATUS, 32'h0, 32'h0);
    csr_row(csr_op_write, `CSR_MISA, 32'hFFFF_FFFF, `CSR_MISA_RESET);
    csr_row(csr_op_set, `CSR_MISA, 32'h0, `CSR_MISA_RESET);
    csr_row(csr_op_write, `CSR_MSCRATCH, 32'h1234_5678, 32'h0);
    csr_row(csr_op_set, `CSR_MSCRATCH, 32'h0F00_00F0, 32'h1234_5678);
    csr_row(csr_op_clear, `CSR_MSCRATCH, 32'h0000_0678, 32'h1F34_56F8);
    csr_row(csr_op_set, `CSR_MSCRATCH, 32'h0, 32'h1F34_5080);
    csr_row(csr_op_write, `CSR_MSTATUS, 32'hFFFF_FFFF, 32'h0);
    csr_row(csr_op_write, `CSR_MSTATUS, 32'h0000_0008, 32'h0000_1888);  // Only mie kept.
    csr_row(csr_op_write, `CSR_MTVEC, 32'h0000_1000, 32'h0);
    trap_row(0, 1, 4'd2, 32'h0000_0400, 32'hDEAD_BEEF, 0, 1, 0, 32'h0000_1000, 32'h0000_0400);
    csr_row(csr_op_set, `CSR_MCAUSE, 32'h0, 32'h0000_0002);
    csr_row(csr_op_set, `CSR_MTVAL, 32'h0, 32'hDEAD_BEEF);
    csr_row(csr_op_set, `CSR_MSTATUS, 32'h0, 32'h0000_0080);
    trap_row(0, 0, 4'd0, 32'h0, 32'h0, 1, 0, 1, 32'h0, 32'h0);
    csr_row(csr_op_set, `CSR_MSTATUS, 32'h0, 32'h0000_0088);
    csr_row(csr_op_write, `CSR_MTVEC, 32'h0000_2001, 32'h0000_1000);  // Vectored.
    csr_row(csr_op_write, `CSR_MIE, 32'h0000_0888, 32'h0);
    csr_row(csr_op_write, `CSR_MTIMECMP, 32'h0000_0040, 32'hFFFF_FFFF);
    csr_row(csr_op_write, `CSR_MTIMECMPH, 32'h0, 32'hFFFF_FFFF);
    count_row(k_poll, `CSR_MIP, 32'h0000_0080, 32'h0000_0080);
    row_lines = 3'b101;  // External and software lines high.
    count_row(k_poll, `CSR_MIP, 32'h0000_0888, 32'h0000_0888);
    trap_row(1, 0, 4'd0, 32'h0000_0500, 32'h0, 0, 1, 0, 32'h0000_202C, 32'h0000_0500);
    csr_row(csr_op_set, `CSR_MCAUSE, 32'h0, 32'h8000_000B);
    csr_row(csr_op_set, `CSR_MSTATUS, 32'h0, 32'h0000_0080);
    trap_row(1, 0, 4'd0, 32'h0000_0600, 32'h0, 0, 0, 0, 32'h0, 32'h0);
    row_lines = '0;
    csr_row(csr_op_write, `CSR_MTIMECMP, 32'hFFFF_FFFF, 32'h0000_0040);
    csr_row(csr_op_write, `CSR_MTIMECMPH, 32'hFFFF_FFFF, 32'h0);
    count_row(k_poll, `CSR_MIP, 32'h0000_0888, 32'h0);
    count_row(k_snap, `CSR_MCYCLE, 32'h0, 32'h0);
    count_row(k_grow, `CSR_MCYCLE, 32'h0, 32'h0);
    count_row(k_snap, `CSR_MINSTRET, 32'h0, 32'h0);
    repeat (3) trap_row(1, 0, 4'd0, 32'h0, 32'h0, 0, 0, 0, 32'h0, 32'h0);
    count_row(k_delta, `CSR_MINSTRET, 32'h0, 32'd3);

    limit = steps.size() * 40 + 200;
    repeat (8) @(posedge clk);
    rst <= 1'b1;

    foreach (steps[n]) begin
      s = steps[n];
      @(posedge clk);
      meip <= s.lines.external;
      msip <= s.lines.software;
      case (s.kind)
        k_csr: begin
          do_csr_op(s, got);
          check_value($sformatf("rsp.rdata[0x%03h]", s.addr), got, s.exp);
        end
        k_trap: apply_trap(s);
        k_poll: begin
          tries = 0;
          do_csr_op(s, got);
          while ((got & s.mask) !== s.exp && tries < 20) begin
            do_csr_op(s, got);
            tries++;
          end
          if ((got & s.mask) !== s.exp) begin
            stop_run($sformatf("CSR 0x%03h never reached 0x%08h under mask 0x%08h",
                               s.addr, s.exp, s.mask));
          end
        end
        k_snap: do_csr_op(s, snap);
        k_grow: begin
          do_csr_op(s, got);
          check_value("mcycle increased", got > snap, 1);
        end
        k_delta: begin
          do_csr_op(s, got);
          check_value("minstret delta", got - snap, s.exp);
        end
        default: stop_run("table holds a step of unknown kind");
      endcase
    end

    $display(">>> PASS");
    $finish;
  end

endmodule

//--- flist.f
+incdir+verilog
verilog/csr_pkg.sv
verilog/csr_op_unit.sv
verilog/machine_timer.sv
verilog/csr_regfile.sv
verilog/csr_subsys.sv
bench/tb_csr_subsys.sv

//--- verilog/csr_macros.svh
`ifndef CSR_MACROS_SVH
`define CSR_MACROS_SVH

`define CSR_XLEN 32

// Machine CSR addresses ---------------------
`define CSR_MSTATUS   12'h300
`define CSR_MISA      12'h301
`define CSR_MIE       12'h304
`define CSR_MTVEC     12'h305
`define CSR_MSCRATCH  12'h340
`define CSR_MEPC      12'h341
`define CSR_MCAUSE    12'h342
`define CSR_MTVAL     12'h343
`define CSR_MIP       12'h344
`define CSR_MCYCLE    12'hB00
`define CSR_MCYCLEH   12'hB80
`define CSR_MINSTRET  12'hB02
`define CSR_MINSTRETH 12'hB82
`define CSR_TIME      12'hC01
`define CSR_TIMEH     12'hC81
`define CSR_MTIMECMP  12'h7C0  // Custom, replaces the memory-mapped register.
`define CSR_MTIMECMPH 12'h7C1

`define CSR_MISA_RESET 32'h4000_0100  // MXL=1, I only.

`endif

//--- verilog/csr_op_unit.sv
`timescale 1ns/100ps
`include "csr_macros.svh"

module csr_op_unit (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 req_valid,
  input  csr_pkg::csr_req_t    req,
  output logic                 req_ready,
  output logic                 rsp_valid,
  output csr_pkg::csr_rsp_t    rsp,
  input  logic                 rsp_ready,
  output csr_pkg::csr_port_t   port,
  input  logic [`CSR_XLEN-1:0] rf_rdata,
  output logic                 tmr_wren,
  output logic                 tmr_hi,
  output logic [`CSR_XLEN-1:0] tmr_wdata,
  input  logic [`CSR_XLEN-1:0] tmr_rdata
);
  import csr_pkg::*;

  logic                 accept;
  logic                 is_timer;
  logic                 is_cmp;
  logic [`CSR_XLEN-1:0] old_val;
  logic [`CSR_XLEN-1:0] new_val;

  assign req_ready = !rsp_valid || rsp_ready;
  assign accept    = req_valid && req_ready;

  // Address decode ----------------------------
  always_comb begin
    is_timer = 1'b0;
    is_cmp   = 1'b0;
    case (req.addr)
      `CSR_TIME, `CSR_TIMEH: is_timer = 1'b1;  // Read only.
      `CSR_MTIMECMP, `CSR_MTIMECMPH: begin
        is_timer = 1'b1;
        is_cmp   = 1'b1;
      end
      default: ;
    endcase
  end

  assign old_val = is_timer ? tmr_rdata : rf_rdata;

  always_comb begin
    case (req.op)
      csr_op_set:   new_val = old_val | req.operand;
      csr_op_clear: new_val = old_val & ~req.operand;
      default:      new_val = req.operand;
    endcase
  end

  always_comb begin
    port.rdaddr = req.addr;
    port.wren   = accept && !is_timer;
    port.wraddr = req.addr;
    port.wdata  = new_val;
  end

  assign tmr_wren  = accept && is_cmp;
  assign tmr_hi    = (req.addr == `CSR_MTIMECMPH);
  assign tmr_wdata = new_val;

  always_ff @(posedge clk) begin
    if (!rst) begin
      rsp_valid <= 1'b0;
    end else if (accept) begin
      rsp_valid <= 1'b1;
    end else if (rsp_ready) begin
      rsp_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      rsp.rdata <= old_val;
    end
  end

  a_rsp_hold: assert property (@(posedge clk) disable iff (!rst)
    rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp));

endmodule

//--- verilog/csr_pkg.sv
`include "csr_macros.svh"

package csr_pkg;

  // Encoding follows funct3[1:0] of the CSR instructions.
  typedef enum logic [1:0] {
    csr_op_write = 2'b01,
    csr_op_set   = 2'b10,
    csr_op_clear = 2'b11
  } csr_op_e;

  typedef struct packed {
    csr_op_e              op;
    logic [11:0]          addr;
    logic [`CSR_XLEN-1:0] operand;
  } csr_req_t;

  typedef struct packed {
    logic [`CSR_XLEN-1:0] rdata;  // Value before the write.
  } csr_rsp_t;

  typedef struct packed {
    logic [18:0] rsvd_31_13;
    logic [1:0]  mpp;
    logic [2:0]  rsvd_10_8;
    logic        mpie;
    logic [2:0]  rsvd_6_4;
    logic        mie;
    logic [2:0]  rsvd_2_0;
  } mstatus_t;

  typedef union packed {
    logic [`CSR_XLEN-1:0] raw;
    mstatus_t             mstatus;
  } csr_word_u;

  typedef struct packed {
    logic [11:0]          rdaddr;
    logic                 wren;
    logic [11:0]          wraddr;
    logic [`CSR_XLEN-1:0] wdata;
  } csr_port_t;

  typedef struct packed {
    logic external;
    logic timer;
    logic software;
  } irq_bits_t;

  typedef struct packed {
    logic                 retire_valid;
    logic                 exception;
    logic [3:0]           ecause;
    logic [`CSR_XLEN-1:0] epc;
    logic [`CSR_XLEN-1:0] etval;
    logic                 mret;
  } trap_in_t;

  typedef struct packed {
    logic                 trap_taken;
    logic                 mret_taken;
    logic [`CSR_XLEN-1:0] mepc;
    logic [`CSR_XLEN-1:0] target;
  } trap_out_t;

  localparam logic [3:0] irq_cause_ext   = 4'd11;
  localparam logic [3:0] irq_cause_timer = 4'd7;
  localparam logic [3:0] irq_cause_soft  = 4'd3;

endpackage

//--- verilog/csr_regfile.sv
`timescale 1ns/100ps
`include "csr_macros.svh"

module csr_regfile (
  input  logic                 clk,
  input  logic                 rst,
  input  csr_pkg::csr_port_t   port,
  output logic [`CSR_XLEN-1:0] rdata,
  input  csr_pkg::trap_in_t    trap,
  output csr_pkg::trap_out_t   tout,
  input  logic                 meip,
  input  logic                 msip,
  input  logic                 mtip
);
  import csr_pkg::*;

  mstatus_t               mstatus;
  irq_bits_t              mie_reg;
  irq_bits_t              mip_reg;
  logic [`CSR_XLEN-1:0]   mtvec;
  logic [`CSR_XLEN-1:0]   mscratch;
  logic [`CSR_XLEN-1:0]   mepc;
  logic [`CSR_XLEN-1:0]   mcause;
  logic [`CSR_XLEN-1:0]   mtval;
  logic [2*`CSR_XLEN-1:0] mcycle;
  logic [2*`CSR_XLEN-1:0] minstret;
  logic                   trap_taken;
  logic                   mret_taken;

  csr_word_u            wword;
  irq_bits_t            pend;
  logic                 irq_take;
  logic                 take_trap;
  logic [3:0]           irq_code;
  logic [`CSR_XLEN-1:0] tvec_base;
  logic [`CSR_XLEN-1:0] target;

  function automatic logic [`CSR_XLEN-1:0] irq_word(input irq_bits_t b);
    irq_word     = '0;
    irq_word[11] = b.external;
    irq_word[7]  = b.timer;
    irq_word[3]  = b.software;
  endfunction

  // Read mux ----------------------------------
  always_comb begin
    case (port.rdaddr)
      `CSR_MSTATUS:   rdata = mstatus;
      `CSR_MISA:      rdata = `CSR_MISA_RESET;
      `CSR_MIE:       rdata = irq_word(mie_reg);
      `CSR_MIP:       rdata = irq_word(mip_reg);
      `CSR_MTVEC:     rdata = mtvec;
      `CSR_MSCRATCH:  rdata = mscratch;
      `CSR_MEPC:      rdata = mepc;
      `CSR_MCAUSE:    rdata = mcause;
      `CSR_MTVAL:     rdata = mtval;
      `CSR_MCYCLE:    rdata = mcycle[`CSR_XLEN-1:0];
      `CSR_MCYCLEH:   rdata = mcycle[2*`CSR_XLEN-1:`CSR_XLEN];
      `CSR_MINSTRET:  rdata = minstret[`CSR_XLEN-1:0];
      `CSR_MINSTRETH: rdata = minstret[2*`CSR_XLEN-1:`CSR_XLEN];
      default:        rdata = '0;
    endcase
  end

  // Interrupt selection -----------------------
  assign wword.raw = port.wdata;
  assign pend      = mie_reg & mip_reg;
  assign irq_take  = !trap.exception && mstatus.mie && trap.retire_valid && (|pend);
  assign take_trap = trap.exception || irq_take;

  always_comb begin
    if (pend.external) begin
      irq_code = irq_cause_ext;
    end else if (pend.timer) begin
      irq_code = irq_cause_timer;
    end else begin
      irq_code = irq_cause_soft;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      mstatus    <= '0;
      mie_reg    <= '0;
      mip_reg    <= '0;
      mtvec      <= '0;
      mscratch   <= '0;
      mepc       <= '0;
      mcause     <= '0;
      mtval      <= '0;
      mcycle     <= '0;
      minstret   <= '0;
      trap_taken <= 1'b0;
      mret_taken <= 1'b0;
    end else begin
      mip_reg <= '{external: meip, timer: mtip, software: msip};  // One cycle late.
      mcycle  <= mcycle + 1'b1;
      if (trap.retire_valid) begin
        minstret <= minstret + 1'b1;
      end

      if (port.wren) begin
        case (port.wraddr)
          `CSR_MSTATUS: begin
            mstatus.mie  <= wword.mstatus.mie;
            mstatus.mpie <= wword.mstatus.mpie;
            mstatus.mpp  <= wword.mstatus.mpp;
          end
          `CSR_MIE: mie_reg <= '{external: wword.raw[11], timer: wword.raw[7],
                                 software: wword.raw[3]};
          `CSR_MTVEC:     mtvec <= {wword.raw[31:2], 1'b0, wword.raw[0]};  // Modes 0 and 1.
          `CSR_MSCRATCH:  mscratch <= wword.raw;
          `CSR_MEPC:      mepc <= {wword.raw[31:2], 2'b00};
          `CSR_MCAUSE:    mcause <= wword.raw;
          `CSR_MTVAL:     mtval <= wword.raw;
          `CSR_MCYCLE:    mcycle <= {mcycle[2*`CSR_XLEN-1:`CSR_XLEN], wword.raw};
          `CSR_MCYCLEH:   mcycle <= {wword.raw, mcycle[`CSR_XLEN-1:0]};
          `CSR_MINSTRET:  minstret <= {minstret[2*`CSR_XLEN-1:`CSR_XLEN], wword.raw};
          `CSR_MINSTRETH: minstret <= {wword.raw, minstret[`CSR_XLEN-1:0]};
          default: ;
        endcase
      end

      // Trap and mret come last so they override a CSR write.
      if (take_trap) begin
        mepc         <= trap.epc;
        mcause       <= trap.exception ? {28'b0, trap.ecause} : {1'b1, 27'b0, irq_code};
        mtval        <= trap.exception ? trap.etval : '0;
        mstatus.mpie <= mstatus.mie;
        mstatus.mie  <= 1'b0;
      end else if (trap.mret) begin
        mstatus.mie  <= mstatus.mpie;
        mstatus.mpie <= 1'b1;
      end
      trap_taken <= take_trap;
      mret_taken <= trap.mret && !take_trap;
    end
  end

  // Trap vector -------------------------------
  always_comb begin
    tvec_base = {mtvec[31:2], 2'b00};
    if (mtvec[1:0] == 2'b01 && mcause[31]) begin
      target = tvec_base + {26'b0, mcause[3:0], 2'b00};  // Vectored interrupt.
    end else begin
      target = tvec_base;
    end
    tout = '{trap_taken: trap_taken, mret_taken: mret_taken, mepc: mepc, target: target};
  end

  a_exc_mret_excl: assert property (@(posedge clk) disable iff (!rst)
    !(trap.exception && trap.mret));

endmodule

//--- verilog/csr_subsys.sv
`timescale 1ns/100ps
`include "csr_macros.svh"

module csr_subsys (
  input  logic                clk,
  input  logic                rst,
  input  logic                req_valid,
  input  csr_pkg::csr_req_t   req,
  output logic                req_ready,
  output logic                rsp_valid,
  output csr_pkg::csr_rsp_t   rsp,
  input  logic                rsp_ready,
  input  csr_pkg::trap_in_t   trap_in,
  output csr_pkg::trap_out_t  trap_out,
  input  logic                meip,
  input  logic                msip
);
  import csr_pkg::*;

  csr_port_t            csr_port;
  logic [`CSR_XLEN-1:0] rf_rdata;
  logic                 tmr_wren;
  logic                 tmr_hi;
  logic [`CSR_XLEN-1:0] tmr_wdata;
  logic [`CSR_XLEN-1:0] tmr_rdata;
  logic                 mtip;

  csr_op_unit u_op (
    .clk, .rst, .req_valid, .req, .req_ready, .rsp_valid, .rsp, .rsp_ready,
    .port(csr_port), .rf_rdata, .tmr_wren, .tmr_hi, .tmr_wdata, .tmr_rdata
  );

  machine_timer u_timer (
    .clk, .rst, .rdaddr(csr_port.rdaddr), .wren(tmr_wren), .hi(tmr_hi),
    .wdata(tmr_wdata), .rdata(tmr_rdata), .mtip
  );

  csr_regfile u_regfile (
    .clk, .rst, .port(csr_port), .rdata(rf_rdata), .trap(trap_in),
    .tout(trap_out), .meip, .msip, .mtip
  );

endmodule

//--- verilog/machine_timer.sv
`timescale 1ns/100ps
`include "csr_macros.svh"

module machine_timer (
  input  logic                 clk,
  input  logic                 rst,
  input  logic [11:0]          rdaddr,
  input  logic                 wren,
  input  logic                 hi,
  input  logic [`CSR_XLEN-1:0] wdata,
  output logic [`CSR_XLEN-1:0] rdata,
  output logic                 mtip
);

  logic [2*`CSR_XLEN-1:0] mtime;
  logic [2*`CSR_XLEN-1:0] mtimecmp;

  always_ff @(posedge clk) begin
    if (!rst) begin
      mtime    <= '0;
      mtimecmp <= '1;  // No interrupt out of reset.
    end else begin
      mtime <= mtime + 1'b1;
      if (wren) begin
        if (hi) begin
          mtimecmp[2*`CSR_XLEN-1:`CSR_XLEN] <= wdata;
        end else begin
          mtimecmp[`CSR_XLEN-1:0] <= wdata;
        end
      end
    end
  end

  assign mtip = (mtime >= mtimecmp);

  always_comb begin
    case (rdaddr)
      `CSR_TIME:      rdata = mtime[`CSR_XLEN-1:0];
      `CSR_TIMEH:     rdata = mtime[2*`CSR_XLEN-1:`CSR_XLEN];
      `CSR_MTIMECMP:  rdata = mtimecmp[`CSR_XLEN-1:0];
      `CSR_MTIMECMPH: rdata = mtimecmp[2*`CSR_XLEN-1:`CSR_XLEN];
      default:        rdata = '0;
    endcase
  end

endmodule
